// ==== compile.f ====
+incdir+tests
source/frame_pkg.sv
source/vote_pkg.sv
source/copy_capture.sv
source/copy_buffer_bank.sv
source/pair_compare.sv
source/majority_vote.sv
source/frame_replay.sv
source/redundant_frame_voter.sv
tests/tb_frame_voter.sv

// ==== run_sim.sh ====
#!/bin/sh
# build the testbench with Verilator, run it and scan the log
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_frame_voter \
	-f compile.f --Mdir obj_dir -o tb_frame_voter \
	&& ./obj_dir/tb_frame_voter > sim.log 2>&1 \
	|| { cat sim.log 2>/dev/null; echo "build or simulation failed"; exit 1; }
cat sim.log
grep -q "STATUS: FAIL" sim.log && { echo "simulation reported failure"; exit 1; }
grep -q "STATUS: PASS" sim.log || { echo "no result line in log"; exit 1; }
exit 0

// ==== source/copy_buffer_bank.sv ====
`timescale 1ns/1ps
`default_nettype none

module copy_buffer_bank #(
	parameter int NUM_COPIES = 5,
	parameter int BUF_AW = 12
) (
	input  wire logic                             clk,
	input  wire vote_pkg::copy_mask_t             wr_en,
	input  wire logic [BUF_AW-1:0]                wr_addr,
	input  wire frame_pkg::byte_t                 wr_data,
	input  wire logic                             sweep_active,
	input  wire logic [BUF_AW-1:0]                sweep_addr,
	input  wire logic [BUF_AW-1:0]                replay_addr,
	output frame_pkg::byte_t [NUM_COPIES-1:0]     rd_data
);

	logic [BUF_AW-1:0] rd_addr;

	// sweep has the read port first, replay gets it afterwards
	assign rd_addr = sweep_active ? sweep_addr : replay_addr;

	for (genvar c = 0; c < NUM_COPIES; c++) begin : g_copy
		frame_pkg::byte_t mem [2**BUF_AW];
		frame_pkg::byte_t q;

		always_ff @(posedge clk) begin
			if (wr_en[c])
				mem[wr_addr] <= wr_data; // port a, capture side
			q <= mem[rd_addr]; // port b, registered read
		end

		assign rd_data[c] = q;
	end

endmodule

`default_nettype wire

// ==== source/copy_capture.sv ====
`timescale 1ns/1ps
`default_nettype none

module copy_capture #(
	parameter int NUM_COPIES = 5,
	parameter int ID_OFFSET = 22,
	parameter int BUF_AW = 12
) (
	input  wire logic                           clk,
	input  wire logic                           rst_n,
	input  wire frame_pkg::rx_beat_t            in,
	input  wire logic                           sweep_active,
	input  wire logic                           replay_busy,
	output vote_pkg::copy_mask_t                wr_en,
	output logic [BUF_AW-1:0]                   wr_addr,
	output frame_pkg::byte_t                    wr_data,
	output logic [NUM_COPIES-1:0][BUF_AW:0]     lengths,
	output vote_pkg::copy_mask_t                received,
	output logic                                set_ready
);

	localparam int CNT_W = $clog2(ID_OFFSET + 2);
	localparam logic [CNT_W-1:0] ID_POS = CNT_W'(ID_OFFSET);
	localparam logic [CNT_W-1:0] PAY_POS = CNT_W'(ID_OFFSET + 1); // saturates here

	logic busy;
	logic valid_q;
	logic pkt_start;
	logic pkt_end;
	logic accept;
	logic skip_q;
	logic pay_beat;
	logic [CNT_W-1:0] byte_cnt;
	logic [frame_pkg::ID_FIELD_BITS-1:0] id_field;
	logic id_ok;
	vote_pkg::copy_idx_t id_q;
	logic [BUF_AW:0] pay_cnt;
	logic set_closed;

	assign busy = sweep_active | replay_busy | set_ready;
	assign pkt_start = in.valid & ~valid_q;
	assign pkt_end = ~in.valid & valid_q;
	assign accept = pkt_start ? ~busy : ~skip_q; // decided once per packet
	assign id_field = in.data[frame_pkg::ID_FIELD_BITS-1:0];
	assign pay_beat = in.valid && byte_cnt == PAY_POS && id_ok;

	// ========================================================================
	// packet framing and id detection
	// ========================================================================

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			valid_q <= 1'b0;
			skip_q <= 1'b0;
			byte_cnt <= '0;
			id_ok <= 1'b0;
			id_q <= '0;
			pay_cnt <= '0;
		end else begin
			valid_q <= in.valid;
			if (!in.valid) begin
				byte_cnt <= '0;
				id_ok <= 1'b0;
			end else begin
				if (pkt_start)
					skip_q <= busy;
				if (byte_cnt != PAY_POS)
					byte_cnt <= byte_cnt + 1'b1;
				if (byte_cnt == ID_POS) begin
					id_ok <= accept && id_field != '0 && id_field <= NUM_COPIES;
					id_q <= vote_pkg::copy_idx_t'(id_field);
					pay_cnt <= '0;
				end else if (pay_beat && !pay_cnt[BUF_AW]) begin
					pay_cnt <= pay_cnt + 1'b1; // stops at 2**BUF_AW
				end
			end
		end
	end

	// write port, one copy at a time
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			wr_en <= '0;
		end else begin
			wr_en <= '0;
			if (pay_beat && !pay_cnt[BUF_AW])
				wr_en[id_q - 3'd1] <= 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		wr_addr <= pay_cnt[BUF_AW-1:0];
		wr_data <= in.data;
	end

	// ========================================================================
	// per-copy bookkeeping and set trigger
	// ========================================================================

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			lengths <= '0;
			received <= '0;
			set_ready <= 1'b0;
			set_closed <= 1'b0;
		end else begin
			set_ready <= 1'b0;
			// mask holds the closed set until the next one starts
			if (pkt_start && !busy && set_closed) begin
				received <= '0;
				set_closed <= 1'b0;
			end
			if (pkt_end && id_ok) begin
				received[id_q - 3'd1] <= 1'b1;
				lengths[id_q - 3'd1] <= pay_cnt;
				if (id_q == NUM_COPIES) begin
					set_ready <= 1'b1; // last copy closes the set
					set_closed <= 1'b1;
				end
			end
		end
	end

	// buffers are never written while the sweep owns them
	a_wr_onehot: assert property (@(posedge clk) disable iff (!rst_n)
		(wr_en != '0) |-> $onehot(wr_en) && !sweep_active);

endmodule

`default_nettype wire

// ==== source/frame_pkg.sv ====
`default_nettype none

package frame_pkg;

	// ========================================================================
	// stream beat types
	// ========================================================================

	typedef logic [7:0] byte_t;

	// copy number sits in the low bits of the id byte
	localparam int ID_FIELD_BITS = 4;

	typedef struct packed {
		logic  valid; // high for every byte of a packet
		byte_t data;
	} rx_beat_t;

	typedef struct packed {
		logic  valid;
		byte_t data;
	} tx_beat_t;

endpackage

`default_nettype wire

// ==== source/frame_replay.sv ====
`timescale 1ns/1ps
`default_nettype none

module frame_replay #(
	parameter int NUM_COPIES = 5,
	parameter int BUF_AW = 12
) (
	input  wire logic                              clk,
	input  wire logic                              rst_n,
	input  wire vote_pkg::vote_result_t            result,
	input  wire logic                              vote_valid,
	input  wire logic [NUM_COPIES-1:0][BUF_AW:0]   lengths,
	input  wire frame_pkg::byte_t [NUM_COPIES-1:0] rd_data,
	output logic [BUF_AW-1:0]                      replay_addr,
	output frame_pkg::tx_beat_t                    out,
	output logic                                   set_done,
	output logic                                   lost,
	output logic                                   replay_busy
);

	logic active;
	logic rd_vld; // rd_data carries a payload byte
	logic [BUF_AW:0] addr_q;
	logic [BUF_AW:0] len_q;
	vote_pkg::copy_idx_t sel_q; // winner, zero based
	logic lost_q;

	// address 0 is already on the bus while vote_valid is high
	assign replay_addr = addr_q[BUF_AW-1:0];
	assign replay_busy = vote_valid | active;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			active <= 1'b0;
			rd_vld <= 1'b0;
			addr_q <= '0;
			len_q <= '0;
			sel_q <= '0;
			lost_q <= 1'b0;
			out <= '0;
			set_done <= 1'b0;
			lost <= 1'b0;
		end else begin
			set_done <= 1'b0;
			out.valid <= rd_vld;
			out.data <= rd_data[sel_q];
			if (vote_valid) begin
				if (result.found) begin
					active <= 1'b1;
					addr_q <= 1'd1;
					sel_q <= result.winner - 3'd1;
					len_q <= lengths[result.winner - 3'd1];
					lost_q <= result.lost;
					rd_vld <= lengths[result.winner - 3'd1] != '0;
				end else begin
					set_done <= 1'b1; // nothing to replay
					lost <= result.lost;
				end
			end else if (active) begin
				if (addr_q < len_q) begin
					addr_q <= addr_q + 1'b1;
					rd_vld <= 1'b1;
				end else begin
					rd_vld <= 1'b0;
					if (!rd_vld) begin // last byte left the output reg
						active <= 1'b0;
						addr_q <= '0;
						set_done <= 1'b1;
						lost <= lost_q;
					end
				end
			end
		end
	end

	a_no_early_out: assert property (@(posedge clk) disable iff (!rst_n)
		vote_valid |-> !$rose(out.valid));

endmodule

`default_nettype wire

// ==== source/majority_vote.sv ====
`timescale 1ns/1ps
`default_nettype none

module majority_vote #(
	parameter int NUM_COPIES = 5
) (
	input  wire logic                  clk,
	input  wire logic                  rst_n,
	input  wire vote_pkg::pair_flags_t flags,
	input  wire logic                  flags_valid,
	input  wire vote_pkg::copy_mask_t  received,
	output vote_pkg::vote_result_t     result,
	output logic                       vote_valid
);

	localparam int NEED = NUM_COPIES / 2; // other copies a winner must match

	logic [2:0] votes;
	logic found_c;
	vote_pkg::copy_idx_t pick;
	logic all_match;
	logic lost_c;

	// walk down so the lowest qualifying copy is the one kept
	always_comb begin
		found_c = 1'b0;
		pick = '0;
		votes = '0;
		for (int c = NUM_COPIES - 1; c >= 0; c--) begin
			votes = '0;
			for (int o = 0; o < NUM_COPIES; o++) begin
				if (o < c)
					votes = votes + 3'(flags[vote_pkg::pair_idx(o, c)]);
				else if (o > c)
					votes = votes + 3'(flags[vote_pkg::pair_idx(c, o)]);
			end
			if (received[c] && votes >= NEED) begin
				found_c = 1'b1;
				pick = vote_pkg::copy_idx_t'(c + 1);
			end
		end
	end

	// clean set only when every copy came and all agree
	always_comb begin
		all_match = 1'b1;
		for (int i = 0; i < NUM_COPIES; i++) begin
			for (int j = i + 1; j < NUM_COPIES; j++)
				all_match = all_match & flags[vote_pkg::pair_idx(i, j)];
		end
	end

	assign lost_c = !((&received[NUM_COPIES-1:0]) && all_match);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			result <= '0;
			vote_valid <= 1'b0;
		end else begin
			vote_valid <= flags_valid;
			if (flags_valid)
				result <= '{found: found_c, winner: pick, lost: lost_c};
		end
	end

	a_winner_range: assert property (@(posedge clk) disable iff (!rst_n)
		vote_valid && result.found |->
			result.winner >= 1 && result.winner <= NUM_COPIES);

endmodule

`default_nettype wire

// ==== source/pair_compare.sv ====
`timescale 1ns/1ps
`default_nettype none

module pair_compare #(
	parameter int NUM_COPIES = 5,
	parameter int BUF_AW = 12
) (
	input  wire logic                             clk,
	input  wire logic                             rst_n,
	input  wire logic                             set_ready,
	input  wire logic [NUM_COPIES-1:0][BUF_AW:0]  lengths,
	input  wire vote_pkg::copy_mask_t             received,
	input  wire frame_pkg::byte_t [NUM_COPIES-1:0] rd_data,
	output logic                                  sweep_active,
	output logic [BUF_AW-1:0]                     sweep_addr,
	output vote_pkg::pair_flags_t                 flags,
	output logic                                  flags_valid
);

	logic [BUF_AW:0] cnt; // next address to issue
	logic [BUF_AW:0] max_len;
	logic [BUF_AW:0] max_len_c;
	logic cmp_vld; // rd_data holds cmp_addr this cycle
	logic [BUF_AW:0] cmp_addr;
	vote_pkg::copy_mask_t rcv_q;
	vote_pkg::pair_flags_t match;
	vote_pkg::pair_flags_t match_next;
	vote_pkg::pair_flags_t pair_ok;

	assign sweep_addr = cnt[BUF_AW-1:0];

	// longest payload among copies that arrived
	always_comb begin
		max_len_c = '0;
		for (int c = 0; c < NUM_COPIES; c++) begin
			if (received[c] && lengths[c] > max_len_c)
				max_len_c = lengths[c];
		end
	end

	// ========================================================================
	// pairwise match flags
	// ========================================================================

	always_comb begin
		match_next = match;
		pair_ok = '0;
		for (int i = 0; i < NUM_COPIES; i++) begin
			for (int j = i + 1; j < NUM_COPIES; j++) begin
				pair_ok[vote_pkg::pair_idx(i, j)] = rcv_q[i] && rcv_q[j] &&
					lengths[i] == lengths[j];
				// only bytes inside both payloads count
				if (cmp_vld && cmp_addr < lengths[i] && cmp_addr < lengths[j] &&
						rd_data[i] != rd_data[j])
					match_next[vote_pkg::pair_idx(i, j)] = 1'b0;
			end
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			sweep_active <= 1'b0;
			cnt <= '0;
			max_len <= '0;
			cmp_vld <= 1'b0;
			cmp_addr <= '0;
			rcv_q <= '0;
			match <= '0;
			flags <= '0;
			flags_valid <= 1'b0;
		end else begin
			flags_valid <= 1'b0;
			cmp_vld <= 1'b0;
			if (set_ready) begin
				sweep_active <= 1'b1;
				cnt <= '0;
				max_len <= max_len_c;
				rcv_q <= received;
				match <= '1; // every pair agrees until shown otherwise
			end else if (sweep_active) begin
				match <= match_next;
				if (flags_valid) begin
					sweep_active <= 1'b0; // held through the flags cycle
				end else if (cnt == max_len) begin
					flags <= match_next & pair_ok; // last byte lands now
					flags_valid <= 1'b1;
				end else begin
					cnt <= cnt + 1'b1;
					cmp_vld <= 1'b1;
					cmp_addr <= cnt;
				end
			end
		end
	end

endmodule

`default_nettype wire

// ==== source/redundant_frame_voter.sv ====
`timescale 1ns/1ps
`default_nettype none

module redundant_frame_voter #(
	parameter int NUM_COPIES = 5,
	parameter int ID_OFFSET = 22,
	parameter int BUF_AW = 12
) (
	input  wire logic               clk,
	input  wire logic               rst_n,
	input  wire frame_pkg::rx_beat_t in,
	output frame_pkg::tx_beat_t     out,
	output logic                    set_done,
	output logic                    lost
);

	vote_pkg::copy_mask_t wr_en;
	logic [BUF_AW-1:0] wr_addr;
	frame_pkg::byte_t wr_data;
	logic [NUM_COPIES-1:0][BUF_AW:0] lengths;
	vote_pkg::copy_mask_t received;
	logic set_ready;
	logic sweep_active;
	logic [BUF_AW-1:0] sweep_addr;
	logic [BUF_AW-1:0] replay_addr;
	frame_pkg::byte_t [NUM_COPIES-1:0] rd_data;
	vote_pkg::pair_flags_t flags;
	logic flags_valid;
	vote_pkg::vote_result_t result;
	logic vote_valid;
	logic replay_busy;

	copy_capture #(
		.NUM_COPIES(NUM_COPIES),
		.ID_OFFSET(ID_OFFSET),
		.BUF_AW(BUF_AW)
	) u_copy_capture (
		.clk(clk),
		.rst_n(rst_n),
		.in(in),
		.sweep_active(sweep_active),
		.replay_busy(replay_busy),
		.wr_en(wr_en),
		.wr_addr(wr_addr),
		.wr_data(wr_data),
		.lengths(lengths),
		.received(received),
		.set_ready(set_ready)
	);

	copy_buffer_bank #(
		.NUM_COPIES(NUM_COPIES),
		.BUF_AW(BUF_AW)
	) u_copy_buffer_bank (
		.clk(clk),
		.wr_en(wr_en),
		.wr_addr(wr_addr),
		.wr_data(wr_data),
		.sweep_active(sweep_active),
		.sweep_addr(sweep_addr),
		.replay_addr(replay_addr),
		.rd_data(rd_data)
	);

	pair_compare #(
		.NUM_COPIES(NUM_COPIES),
		.BUF_AW(BUF_AW)
	) u_pair_compare (
		.clk(clk),
		.rst_n(rst_n),
		.set_ready(set_ready),
		.lengths(lengths),
		.received(received),
		.rd_data(rd_data),
		.sweep_active(sweep_active),
		.sweep_addr(sweep_addr),
		.flags(flags),
		.flags_valid(flags_valid)
	);

	majority_vote #(
		.NUM_COPIES(NUM_COPIES)
	) u_majority_vote (
		.clk(clk),
		.rst_n(rst_n),
		.flags(flags),
		.flags_valid(flags_valid),
		.received(received),
		.result(result),
		.vote_valid(vote_valid)
	);

	frame_replay #(
		.NUM_COPIES(NUM_COPIES),
		.BUF_AW(BUF_AW)
	) u_frame_replay (
		.clk(clk),
		.rst_n(rst_n),
		.result(result),
		.vote_valid(vote_valid),
		.lengths(lengths),
		.rd_data(rd_data),
		.replay_addr(replay_addr),
		.out(out),
		.set_done(set_done),
		.lost(lost),
		.replay_busy(replay_busy)
	);

endmodule

`default_nettype wire

// ==== source/vote_pkg.sv ====
`default_nettype none

package vote_pkg;

	// ========================================================================
	// copy and vote types
	// ========================================================================

	localparam int MAX_COPIES = 7;
	localparam int NUM_PAIRS = MAX_COPIES * (MAX_COPIES - 1) / 2;

	typedef logic [2:0] copy_idx_t; // 0 = no copy
	typedef logic [MAX_COPIES-1:0] copy_mask_t;
	typedef logic [NUM_PAIRS-1:0] pair_flags_t; // 1-2, 1-3 .. 6-7

	typedef struct packed {
		logic      found;
		copy_idx_t winner; // 1 based
		logic      lost;
	} vote_result_t;

	// Bit position of the pair (a, b) in pair_flags_t.
	// Both indices are zero based and a < b.
	function automatic int pair_idx(input int a, input int b);
		return a * (2 * MAX_COPIES - a - 1) / 2 + (b - a - 1);
	endfunction

endpackage

`default_nettype wire

// ==== tests/frame_model.svh ====
`ifndef FRAME_MODEL_SVH
`define FRAME_MODEL_SVH

// ============================================================================
// frame builders
// ============================================================================

function automatic int rand_below(input int n);
	return int'($unsigned($random(seed)) % n);
endfunction

function automatic frame_pkg::byte_t random_byte();
	return frame_pkg::byte_t'(rand_below(256));
endfunction

function automatic void fill_payload(input int c, input int n);
	for (int i = 0; i < n; i++)
		pay[c][i] = random_byte();
	len[c] = n;
endfunction

function automatic void copy_payload(input int dst, input int src);
	pay[dst] = pay[src];
	len[dst] = len[src];
endfunction

function automatic void flip_byte(input int c);
	int pos;
	frame_pkg::byte_t mask;
	pos = rand_below(len[c]);
	mask = frame_pkg::byte_t'(1 + rand_below(255)); // never zero
	pay[c][pos] = pay[c][pos] ^ mask;
endfunction

function automatic void set_length(input int c, input int n);
	for (int i = len[c]; i < n; i++)
		pay[c][i] = random_byte(); // new tail bytes
	len[c] = n;
endfunction

function automatic void resize_payload(input int c);
	int n;
	n = 1 + rand_below(40);
	if (n == len[c])
		n = (len[c] % 40) + 1;
	set_length(c, n);
endfunction

// ============================================================================
// reference model
// ============================================================================

// missing copies match nobody
function automatic bit copies_match(input int a, input int b);
	if (!sent[a] || !sent[b] || len[a] != len[b])
		return 1'b0;
	for (int i = 0; i < len[a]; i++) begin
		if (pay[a][i] != pay[b][i])
			return 1'b0;
	end
	return 1'b1;
endfunction

function automatic void model_vote();
	int votes;
	int winner;
	bit clean;
	winner = -1;
	clean = 1'b1;
	exp_q.delete();
	for (int a = 0; a < NC; a++) begin
		votes = 0;
		for (int b = 0; b < NC; b++) begin
			if (b != a && copies_match(a, b))
				votes++;
		end
		if (!sent[a] || votes != NC - 1)
			clean = 1'b0;
		if (winner < 0 && sent[a] && votes >= NC / 2)
			winner = a; // lowest qualifying copy
	end
	exp_lost = !clean;
	if (winner >= 0) begin
		for (int i = 0; i < len[winner]; i++)
			exp_q.push_back(pay[winner][i]);
	end
endfunction

`endif

// ==== tests/tb_frame_voter.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_frame_voter;

	localparam int NC = 5;
	localparam int ID_OFFSET = 22;
	localparam int MAXP = 48;
	localparam int TIMEOUT = 2000; // cycles per set

	logic clk;
	logic rst_n;
	frame_pkg::rx_beat_t rx;
	frame_pkg::tx_beat_t tx;
	logic set_done;
	logic lost;

	integer seed;
	int errors;
	int checks;
	bit hung;

	// current set, as sent
	frame_pkg::byte_t pay [NC][MAXP];
	int len [NC];
	bit sent [NC];
	frame_pkg::byte_t exp_q [$];
	frame_pkg::byte_t got_q [$];
	bit exp_lost;
	bit got_lost;
	bit done_seen;

	`include "frame_model.svh"

	redundant_frame_voter u_redundant_frame_voter (
		.clk(clk),
		.rst_n(rst_n),
		.in(rx),
		.out(tx),
		.set_done(set_done),
		.lost(lost)
	);

	always #4 clk = ~clk; // 8 ns period

	// ========================================================================
	// stream driver and monitor
	// ========================================================================

	task automatic drive_byte(input frame_pkg::byte_t b);
		@(posedge clk);
		rx <= '{valid: 1'b1, data: b};
	endtask

	// c < 0 sends a random payload
	task automatic send_packet(input int id, input int c);
		int n;
		n = (c >= 0) ? len[c] : 1 + rand_below(40);
		for (int i = 0; i < ID_OFFSET; i++)
			drive_byte(random_byte()); // header
		drive_byte(frame_pkg::byte_t'(rand_below(16) * 16 + id));
		for (int i = 0; i < n; i++)
			drive_byte((c >= 0) ? pay[c][i] : random_byte());
		repeat (1 + rand_below(3)) begin
			@(posedge clk);
			rx <= '{valid: 1'b0, data: 8'h00};
		end
	endtask

	task automatic collect_output();
		int cycles;
		cycles = 0;
		done_seen = 1'b0;
		got_lost = 1'b0;
		got_q.delete();
		while (!done_seen && cycles < TIMEOUT) begin
			@(negedge clk);
			if (tx.valid)
				got_q.push_back(tx.data);
			if (set_done) begin
				done_seen = 1'b1;
				got_lost = lost;
			end
			cycles++;
		end
	endtask

	task automatic check_set(input string name);
		int n;
		checks++;
		assert (done_seen) else begin
			$display("set_done never arrived in test %s", name);
			errors++;
			hung = 1'b1;
		end
		assert (got_q.size() == exp_q.size()) else begin
			$display("ERR %s beats: expected %0d actual %0d", name, exp_q.size(), got_q.size());
			errors++;
		end
		n = (got_q.size() < exp_q.size()) ? got_q.size() : exp_q.size();
		for (int i = 0; i < n; i++) begin
			assert (got_q[i] == exp_q[i]) else begin
				$display("ERR %s byte %0d: expected %02h actual %02h", name, i, exp_q[i],
					got_q[i]);
				errors++;
			end
		end
		assert (!done_seen || got_lost == exp_lost) else begin
			$display("ERR %s lost: expected %0b actual %0b", name, exp_lost, got_lost);
			errors++;
		end
	endtask

	// ========================================================================
	// scenarios
	// ========================================================================

	task automatic run_set(input int scen, input string name);
		int n;
		int a;
		int b;
		int junk_at;
		if (hung)
			return;
		n = 1 + rand_below(40);
		junk_at = -1;
		fill_payload(0, n);
		for (int c = 0; c < NC; c++) begin
			copy_payload(c, 0);
			sent[c] = 1'b1;
		end
		case (scen)
			2: begin
				a = rand_below(NC);
				if (rand_below(2) != 0)
					flip_byte(a);
				else
					resize_payload(a);
			end
			3: begin
				a = rand_below(NC);
				b = (a + 1 + rand_below(NC - 1)) % NC; // distinct from a
				flip_byte(a);
				resize_payload(b);
			end
			4: begin
				a = rand_below(4);
				sent[a] = 1'b0;
				if (rand_below(2) != 0)
					sent[(a + 1 + rand_below(3)) % 4] = 1'b0;
				junk_at = rand_below(NC);
			end
			5: begin
				sent[2] = 1'b0;
				sent[3] = 1'b0;
				set_length(1, n + 1); // three different lengths
				set_length(4, n + 2);
			end
			default: ;
		endcase
		model_vote();
		for (int c = 0; c < NC; c++) begin
			if (c == junk_at) begin
				send_packet(0, -1); // ids the voter must drop
				send_packet(9, -1);
			end
			if (sent[c])
				send_packet(c + 1, c);
		end
		collect_output();
		check_set(name);
	endtask

	initial begin
		seed = 32'h8c30;
		errors = 0;
		checks = 0;
		hung = 1'b0;
		clk = 1'b0;
		rst_n = 1'b0;
		rx = '0;
		repeat (3) @(posedge clk);
		rst_n <= 1'b1;
		@(negedge clk);
		assert (!tx.valid && !set_done && !lost) else begin
			$display("outputs not idle after reset");
			errors++;
		end
		for (int r = 0; r < 3; r++) begin
			run_set(1, "identical");
			run_set(2, "one_corrupt");
			run_set(3, "two_corrupt");
			run_set(4, "missing_and_bad_id");
			run_set(5, "no_majority");
		end
		for (int r = 0; r < 20; r++)
			run_set(1 + rand_below(5), "back_to_back");
		$display("summary: %0d sets checked, %0d errors", checks, errors);
		if (errors == 0)
			$display("STATUS: PASS");
		else
			$display("STATUS: FAIL");
		$finish;
	end

endmodule

`default_nettype wire
